/* rtl/decode_reg.sv */
`default_nettype none

module decode_reg (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       flush,
  input  wire                       in_valid,
  output logic                      in_ready,
  input  wire rv_pkg::decoded_instr in_data,
  output logic                      out_valid,
  input  wire                       out_ready,
  output rv_pkg::decoded_instr      out_data
);
  import rv_pkg::*;

  logic         valid_q;
  decoded_instr data_q;

  // Empty, or the held item leaves this cycle
  assign in_ready = !valid_q || out_ready;

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      valid_q <= 1'b0;
    end else if (in_ready) begin
      valid_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

  assign out_valid = valid_q;
  assign out_data  = data_q;

endmodule

`default_nettype wire

/* rtl/instr_decode.sv */
`default_nettype none

module instr_decode (
  input  wire                       fetched_valid,
  output logic                      fetched_ready,
  input  wire rv_pkg::fetched_instr fetched,
  output logic                      dec_valid,
  input  wire                       dec_ready,
  output rv_pkg::decoded_instr      dec,
  output rv_pkg::reg_idx            rs_idx [2],
  input  wire rv_pkg::gpreg         rs_val [2]
);
  import rv_pkg::*;

  instr     word;
  instr_op  op;
  instr_fmt fmt;
  logic     has_rs1;
  logic     has_rs2;
  logic     has_rd;
  reg_idx   rs1;
  reg_idx   rs2;
  gpreg     imm;
  logic     sgn;

  assign word = fetched.raw;
  assign sgn  = word[31];

  // Handshake is passed straight through
  assign dec_valid     = fetched_valid;
  assign fetched_ready = dec_ready;

  // Opcode class and format
  always_comb begin
    op  = INSTR_INVAL;
    // Invalid words keep every raw field
    fmt = INSTR_R;
    if (word[1:0] == 2'b11) begin
      case (word[6:2])
        5'b00000: begin
          op  = INSTR_LOAD;
          fmt = INSTR_I;
        end
        5'b00011: begin
          // FENCE flags live in the I immediate
          op  = INSTR_MISC_MEM;
          fmt = INSTR_I;
        end
        5'b00100: begin
          op  = INSTR_OP_IMM;
          fmt = INSTR_I;
        end
        5'b00101: begin
          op  = INSTR_AUIPC;
          fmt = INSTR_U;
        end
        5'b01000: begin
          op  = INSTR_STORE;
          fmt = INSTR_S;
        end
        5'b01100: begin
          op  = INSTR_OP;
          fmt = INSTR_R;
        end
        5'b01101: begin
          op  = INSTR_LUI;
          fmt = INSTR_U;
        end
        5'b11000: begin
          op  = INSTR_BRANCH;
          fmt = INSTR_B;
        end
        5'b11001: begin
          op  = INSTR_JALR;
          fmt = INSTR_I;
        end
        5'b11011: begin
          op  = INSTR_JAL;
          fmt = INSTR_J;
        end
        5'b11100: begin
          op  = INSTR_SYSTEM;
          fmt = INSTR_I;
        end
        default: begin
          op  = INSTR_INVAL;
          fmt = INSTR_R;
        end
      endcase
    end
  end

  // Register fields present per format
  assign has_rs1 = (fmt != INSTR_U) && (fmt != INSTR_J);
  assign has_rs2 = (fmt != INSTR_U) && (fmt != INSTR_J) && (fmt != INSTR_I);
  assign has_rd  = (fmt != INSTR_S) && (fmt != INSTR_B);

  assign rs1 = has_rs1 ? word[19:15] : 5'd0;
  assign rs2 = has_rs2 ? word[24:20] : 5'd0;

  // R format uses the I layout, funct7 ends up in imm[11:5]
  always_comb begin
    case (fmt)
      INSTR_R, INSTR_I: imm = {{20{sgn}}, word[31:20]};
      INSTR_S: imm = {{20{sgn}}, word[31:25], word[11:7]};
      INSTR_B: imm = {{20{sgn}}, word[7], word[30:25], word[11:8], 1'b0};
      INSTR_U: imm = {word[31:12], 12'd0};
      INSTR_J: imm = {{12{sgn}}, word[19:12], word[20], word[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

  assign rs_idx[0] = rs1;
  assign rs_idx[1] = rs2;

  assign dec.op      = op;
  assign dec.fmt     = fmt;
  assign dec.rs1     = rs1;
  assign dec.rs2     = rs2;
  assign dec.rd      = has_rd ? word[11:7] : 5'd0;
  assign dec.funct3  = word[14:12];
  assign dec.imm     = imm;
  assign dec.rs1_val = rs_val[0];
  assign dec.rs2_val = rs_val[1];
  assign dec.pc      = fetched.pc;

endmodule

`default_nettype wire

/* rtl/instr_fetch.sv */
`default_nettype none

module instr_fetch (
  input  wire                      clk,
  input  wire                      reset,
  input  wire rv_pkg::redirect_t   redirect,
  output logic                     mem_rd_en,
  output rv_pkg::addr_t            mem_rd_addr,
  input  wire rv_pkg::instr        mem_rd_data,
  output logic                     fetched_valid,
  input  wire                      fetched_ready,
  output rv_pkg::fetched_instr     fetched
);
  import rv_pkg::*;

  addr_t pc_q;
  logic  rd_pending_q;
  logic  valid_q;
  logic  xfer;

  assign xfer = valid_q && fetched_ready;

  // Redirect has priority over a transfer in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q         <= '0;
      rd_pending_q <= 1'b0;
      valid_q      <= 1'b0;
    end else if (redirect.valid) begin
      pc_q         <= redirect.pc;
      rd_pending_q <= 1'b1;
      valid_q      <= 1'b0;
    end else if (xfer) begin
      pc_q         <= pc_q + 32'd4;
      rd_pending_q <= 1'b1;
      valid_q      <= 1'b0;
    end else if (rd_pending_q) begin
      // Memory samples the address on this edge, data is there next cycle
      rd_pending_q <= 1'b0;
      valid_q      <= 1'b1;
    end
  end

  assign mem_rd_en   = rd_pending_q;
  assign mem_rd_addr = pc_q;

  // Read data register holds the word while rd_en is low
  assign fetched_valid = valid_q;
  assign fetched.pc    = pc_q;
  assign fetched.raw   = mem_rd_data;

endmodule

`default_nettype wire

/* rtl/instr_mem.sv */
`default_nettype none

module instr_mem #(
  parameter int ADDR_BITS = 8
) (
  input  wire                 clk,
  input  wire                 reset,
  input  wire rv_pkg::imem_write_t wr,
  input  wire                 rd_en,
  input  wire rv_pkg::addr_t  rd_addr,
  output rv_pkg::instr        rd_data
);
  import rv_pkg::*;

  localparam int DEPTH = 2 ** ADDR_BITS;

  instr mem [DEPTH];

  // Load port, one word per strobe
  always_ff @(posedge clk) begin
    if (wr.valid) begin
      mem[wr.addr[ADDR_BITS-1:0]] <= wr.data;
    end
  end

  // Byte address in, word select from bit 2 upwards
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr[ADDR_BITS+1:2]];
    end
  end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`default_nettype none

module reg_file (
  input  wire                     clk,
  input  wire                     reset,
  input  wire rv_pkg::writeback_t wb,
  input  wire rv_pkg::reg_idx     rs_idx [2],
  output rv_pkg::gpreg            rs_val [2]
);
  import rv_pkg::*;

  // x0 has no storage
  gpreg regs [1:31];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && (wb.rd != 5'd0)) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // Same-cycle write is forwarded to the reader
  for (genvar p = 0; p < 2; p++) begin : g_read
    always_comb begin
      if (rs_idx[p] == 5'd0) begin
        rs_val[p] = '0;
      end else if (wb.valid && (wb.rd == rs_idx[p])) begin
        rs_val[p] = wb.data;
      end else begin
        rs_val[p] = regs[rs_idx[p]];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_frontend.sv */
`default_nettype none

module rv_frontend #(
  parameter int IMEM_ADDR_BITS = 8
) (
  input  wire                       clk,
  input  wire                       reset,
  input  wire rv_pkg::imem_write_t  imem_wr,
  input  wire rv_pkg::redirect_t    redirect,
  input  wire rv_pkg::writeback_t   writeback,
  output logic                      decoded_valid,
  input  wire                       decoded_ready,
  output rv_pkg::decoded_instr      decoded
);
  import rv_pkg::*;

  logic         mem_rd_en;
  addr_t        mem_rd_addr;
  instr         mem_rd_data;
  logic         fetched_valid;
  logic         fetched_ready;
  fetched_instr fetched;
  logic         dec_valid;
  logic         dec_ready;
  decoded_instr dec;
  reg_idx       rs_idx [2];
  gpreg         rs_val [2];

  instr_mem #(
    .ADDR_BITS(IMEM_ADDR_BITS)
  ) u_mem (
    .clk    (clk),
    .reset  (reset),
    .wr     (imem_wr),
    .rd_en  (mem_rd_en),
    .rd_addr(mem_rd_addr),
    .rd_data(mem_rd_data)
  );

  instr_fetch u_fetch (
    .clk          (clk),
    .reset        (reset),
    .redirect     (redirect),
    .mem_rd_en    (mem_rd_en),
    .mem_rd_addr  (mem_rd_addr),
    .mem_rd_data  (mem_rd_data),
    .fetched_valid(fetched_valid),
    .fetched_ready(fetched_ready),
    .fetched      (fetched)
  );

  instr_decode u_decode (
    .fetched_valid(fetched_valid),
    .fetched_ready(fetched_ready),
    .fetched      (fetched),
    .dec_valid    (dec_valid),
    .dec_ready    (dec_ready),
    .dec          (dec),
    .rs_idx       (rs_idx),
    .rs_val       (rs_val)
  );

  reg_file u_regs (
    .clk   (clk),
    .reset (reset),
    .wb    (writeback),
    .rs_idx(rs_idx),
    .rs_val(rs_val)
  );

  // A redirect also drops whatever sits in the output register
  decode_reg u_out (
    .clk      (clk),
    .reset    (reset),
    .flush    (redirect.valid),
    .in_valid (dec_valid),
    .in_ready (dec_ready),
    .in_data  (dec),
    .out_valid(decoded_valid),
    .out_ready(decoded_ready),
    .out_data (decoded)
  );

endmodule

`default_nettype wire

/* rtl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  typedef logic [4:0]  reg_idx;
  typedef logic [31:0] gpreg;
  typedef logic [31:0] instr;
  typedef logic [31:0] addr_t;

  // Opcode class, taken from instruction bits 6:2
  typedef enum logic [3:0] {
    INSTR_INVAL,
    INSTR_LOAD,
    INSTR_MISC_MEM,
    INSTR_OP_IMM,
    INSTR_AUIPC,
    INSTR_STORE,
    INSTR_OP,
    INSTR_LUI,
    INSTR_BRANCH,
    INSTR_JALR,
    INSTR_JAL,
    INSTR_SYSTEM
  } instr_op;

  typedef enum logic [2:0] {
    INSTR_R,
    INSTR_I,
    INSTR_S,
    INSTR_B,
    INSTR_U,
    INSTR_J
  } instr_fmt;

  typedef struct packed {
    addr_t pc;
    instr  raw;
  } fetched_instr;

  typedef struct packed {
    instr_op    op;
    instr_fmt   fmt;
    reg_idx     rs1;
    reg_idx     rs2;
    reg_idx     rd;
    logic [2:0] funct3;
    gpreg       imm;
    gpreg       rs1_val;
    gpreg       rs2_val;
    addr_t      pc;
  } decoded_instr;

  // Restarts fetch, also flushes the decode stage
  typedef struct packed {
    logic  valid;
    addr_t pc;
  } redirect_t;

  typedef struct packed {
    logic   valid;
    reg_idx rd;
    gpreg   data;
  } writeback_t;

  // addr is a word index here, not a byte address
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    instr        data;
  } imem_write_t;

endpackage

`default_nettype wire

/* rv_frontend.f */
rtl/rv_pkg.sv
rtl/instr_mem.sv
rtl/instr_fetch.sv
rtl/instr_decode.sv
rtl/reg_file.sv
rtl/decode_reg.sv
rtl/rv_frontend.sv
tb/rv_frontend_asserts.sv
tb/tb_rv_frontend.sv

/* tb/rv_frontend_asserts.sv */
`default_nettype none

module rv_frontend_asserts (
  input wire                       clk,
  input wire                       reset,
  input wire rv_pkg::redirect_t    redirect,
  input wire                       decoded_valid,
  input wire                       decoded_ready,
  input wire rv_pkg::decoded_instr decoded
);
  import rv_pkg::*;

  int   fail_count = 0;
  logic seen_redirect;

  always_ff @(posedge clk) begin
    if (reset) begin
      seen_redirect <= 1'b0;
    end else if (redirect.valid) begin
      seen_redirect <= 1'b1;
    end
  end

  // Index fields that a format does not carry read as zero
  a_rd_zero: assert property (@(posedge clk) disable iff (reset)
    decoded_valid && (decoded.fmt inside {INSTR_S, INSTR_B}) |-> decoded.rd == 5'd0)
    else begin
      $error("rd is not zero for an S or B format instruction");
      fail_count++;
    end

  a_rs1_zero: assert property (@(posedge clk) disable iff (reset)
    decoded_valid && (decoded.fmt inside {INSTR_U, INSTR_J}) |-> decoded.rs1 == 5'd0)
    else begin
      $error("rs1 is not zero for a U or J format instruction");
      fail_count++;
    end

  a_rs2_zero: assert property (@(posedge clk) disable iff (reset)
    decoded_valid && (decoded.fmt inside {INSTR_U, INSTR_J, INSTR_I})
      |-> decoded.rs2 == 5'd0)
    else begin
      $error("rs2 is not zero for a U, J or I format instruction");
      fail_count++;
    end

  // Held output under back-pressure
  a_stable: assert property (@(posedge clk) disable iff (reset)
    decoded_valid && !decoded_ready && !redirect.valid
      |=> decoded_valid && $stable(decoded))
    else begin
      $error("decoded changed or dropped while stalled");
      fail_count++;
    end

  a_flush: assert property (@(posedge clk) disable iff (reset)
    redirect.valid |=> !decoded_valid)
    else begin
      $error("decoded_valid still high the cycle after a redirect");
      fail_count++;
    end

  // Strobe to first output is three cycles
  a_restart: assert property (@(posedge clk) disable iff (reset)
    redirect.valid ##1 !redirect.valid [*2]
      |=> decoded_valid && (decoded.pc == $past(redirect.pc, 3)))
    else begin
      $error("first output after a redirect is late or has the wrong pc");
      fail_count++;
    end

  a_idle: assert property (@(posedge clk) disable iff (reset)
    !seen_redirect |-> !decoded_valid)
    else begin
      $error("decoded_valid high before the first redirect");
      fail_count++;
    end

endmodule

bind rv_frontend rv_frontend_asserts u_asserts (
  .clk          (clk),
  .reset        (reset),
  .redirect     (redirect),
  .decoded_valid(decoded_valid),
  .decoded_ready(decoded_ready),
  .decoded      (decoded)
);

`default_nettype wire

/* tb/tb_rv_frontend.sv */
`default_nettype none

module tb_rv_frontend;
  import rv_pkg::*;

  localparam int NUM_WORDS      = 14;
  localparam int MEM_WORDS      = 64;
  localparam int TIMEOUT_CYCLES = NUM_WORDS * 40 + 200;
  localparam int LATE_IDX       = 13;
  localparam logic [31:0] X7_VAL = 32'hCAFE_0007;

  logic         clk;
  logic         reset;
  imem_write_t  imem_wr;
  redirect_t    redirect;
  writeback_t   writeback;
  logic         decoded_valid;
  logic         decoded_ready;
  decoded_instr decoded;

  decoded_instr exp_tab [NUM_WORDS];
  instr         raw_tab [NUM_WORDS];
  gpreg         reg_model [32];
  int           num_loaded = 0;
  int           out_idx = 0;
  int           errors = 0;
  int           seed = 24867;
  logic         wb_done = 1'b0;

  rv_frontend #(
    .IMEM_ADDR_BITS(6)
  ) DUT (
    .clk          (clk),
    .reset        (reset),
    .imem_wr      (imem_wr),
    .redirect     (redirect),
    .writeback    (writeback),
    .decoded_valid(decoded_valid),
    .decoded_ready(decoded_ready),
    .decoded      (decoded)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [6:0] opcode_of(input instr_op op);
    case (op)
      INSTR_LOAD:     return 7'b0000011;
      INSTR_MISC_MEM: return 7'b0001111;
      INSTR_OP_IMM:   return 7'b0010011;
      INSTR_AUIPC:    return 7'b0010111;
      INSTR_STORE:    return 7'b0100011;
      INSTR_OP:       return 7'b0110011;
      INSTR_LUI:      return 7'b0110111;
      INSTR_BRANCH:   return 7'b1100011;
      INSTR_JALR:     return 7'b1100111;
      INSTR_JAL:      return 7'b1101111;
      INSTR_SYSTEM:   return 7'b1110011;
      // OP pattern with low bits 01
      default:        return 7'b0110001;
    endcase
  endfunction

  // Encodes one word and records what decode should make of it
  task automatic add_word(input instr_op op, input instr_fmt fmt, input reg_idx rs1,
                          input reg_idx rs2, input reg_idx rd, input logic [2:0] f3,
                          input logic [31:0] imm);
    logic [6:0]   opc;
    instr         w;
    decoded_instr e;
    opc = opcode_of(op);
    case (fmt)
      INSTR_R: w = {imm[11:5], rs2, rs1, f3, rd, opc};
      INSTR_I: w = {imm[11:0], rs1, f3, rd, opc};
      INSTR_S: w = {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
      INSTR_B: w = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
      INSTR_U: w = {imm[31:12], rd, opc};
      default: w = {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
    endcase
    e        = '0;
    e.op     = op;
    e.fmt    = fmt;
    e.rs1    = (fmt inside {INSTR_U, INSTR_J}) ? 5'd0 : rs1;
    e.rs2    = (fmt inside {INSTR_R, INSTR_S, INSTR_B}) ? rs2 : 5'd0;
    e.rd     = (fmt inside {INSTR_S, INSTR_B}) ? 5'd0 : rd;
    // U and J carry immediate bits where funct3 would sit
    e.funct3 = (fmt inside {INSTR_U, INSTR_J}) ? imm[14:12] : f3;
    case (fmt)
      INSTR_R: e.imm = {{20{imm[11]}}, imm[11:5], rs2};
      INSTR_B: e.imm = {{19{imm[12]}}, imm[12:1], 1'b0};
      INSTR_U: e.imm = {imm[31:12], 12'd0};
      INSTR_J: e.imm = {{11{imm[20]}}, imm[20:1], 1'b0};
      default: e.imm = {{20{imm[11]}}, imm[11:0]};
    endcase
    exp_tab[num_loaded] = e;
    raw_tab[num_loaded] = w;
    num_loaded++;
  endtask

  task automatic check_field(input string name, input int idx, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    assert (act_val === exp_val) else begin
      $display("ERR t=%0t %s (word %0d) expected %h got %h",
               $time, name, idx, exp_val, act_val);
      errors++;
    end
  endtask

  task automatic check_output(input int idx);
    decoded_instr e;
    e         = exp_tab[idx];
    e.rs1_val = reg_model[e.rs1];
    e.rs2_val = reg_model[e.rs2];
    e.pc      = idx * 4;
    check_field("decoded.op", idx, 32'(e.op), 32'(decoded.op));
    check_field("decoded.fmt", idx, 32'(e.fmt), 32'(decoded.fmt));
    check_field("decoded.rs1", idx, 32'(e.rs1), 32'(decoded.rs1));
    check_field("decoded.rs2", idx, 32'(e.rs2), 32'(decoded.rs2));
    check_field("decoded.rd", idx, 32'(e.rd), 32'(decoded.rd));
    check_field("decoded.funct3", idx, 32'(e.funct3), 32'(decoded.funct3));
    check_field("decoded.imm", idx, e.imm, decoded.imm);
    check_field("decoded.rs1_val", idx, e.rs1_val, decoded.rs1_val);
    check_field("decoded.rs2_val", idx, e.rs2_val, decoded.rs2_val);
    check_field("decoded.pc", idx, e.pc, decoded.pc);
  endtask

  // One stimulus cycle with random back-pressure
  task automatic step();
    @(negedge clk);
    decoded_ready = ($random(seed) & 3) != 0;
    writeback     = '0;
    // Write x7 in the same cycle the word that reads it enters the output register
    if (!wb_done && DUT.fetched_valid && (DUT.fetched.pc == LATE_IDX * 4)) begin
      decoded_ready = 1'b1;
      writeback     = '{valid: 1'b1, rd: 5'd7, data: X7_VAL};
      reg_model[7]  = X7_VAL;
      wb_done       = 1'b1;
    end
  endtask

  always @(posedge clk) begin
    if (!reset && decoded_valid && decoded_ready && (out_idx < NUM_WORDS)) begin
      check_output(out_idx);
      out_idx++;
    end
  end

  initial begin
    reset         = 1'b1;
    imem_wr       = '0;
    redirect      = '0;
    writeback     = '0;
    decoded_ready = 1'b0;
    for (int i = 0; i < 32; i++) begin
      reg_model[i] = '0;
    end

    add_word(INSTR_LOAD,     INSTR_I, 5'd1, 5'd0, 5'd6,  3'd2, 32'hFFFF_FFFC);
    add_word(INSTR_MISC_MEM, INSTR_I, 5'd0, 5'd0, 5'd0,  3'd0, 32'h0000_00FF);
    add_word(INSTR_OP_IMM,   INSTR_I, 5'd2, 5'd0, 5'd9,  3'd0, 32'h0000_07FF);
    add_word(INSTR_AUIPC,    INSTR_U, 5'd0, 5'd0, 5'd10, 3'd0, 32'hFFFF_F000);
    add_word(INSTR_STORE,    INSTR_S, 5'd4, 5'd3, 5'd0,  3'd2, 32'hFFFF_FFF8);
    add_word(INSTR_OP,       INSTR_R, 5'd5, 5'd3, 5'd11, 3'd0, 32'h0000_0400);
    add_word(INSTR_LUI,      INSTR_U, 5'd0, 5'd0, 5'd12, 3'd0, 32'h1234_5000);
    add_word(INSTR_BRANCH,   INSTR_B, 5'd1, 5'd2, 5'd0,  3'd0, 32'hFFFF_FFF0);
    add_word(INSTR_JALR,     INSTR_I, 5'd0, 5'd0, 5'd13, 3'd0, 32'h0000_000C);
    add_word(INSTR_JAL,      INSTR_J, 5'd0, 5'd0, 5'd14, 3'd0, 32'hFFFF_F800);
    add_word(INSTR_SYSTEM,   INSTR_I, 5'd3, 5'd0, 5'd15, 3'd1, 32'h0000_0305);
    add_word(INSTR_INVAL,    INSTR_R, 5'd4, 5'd5, 5'd16, 3'd7, 32'h0000_0FE0);
    add_word(INSTR_OP,       INSTR_R, 5'd0, 5'd5, 5'd17, 3'd0, 32'h0000_0000);
    add_word(INSTR_OP,       INSTR_R, 5'd7, 5'd2, 5'd18, 3'd0, 32'h0000_0000);

    repeat (4) @(negedge clk);
    reset = 1'b0;

    // Preset x1 to x5, then try to write x0
    for (int i = 1; i <= 5; i++) begin
      writeback    = '{valid: 1'b1, rd: 5'(i), data: 32'hA5A5_0000 + i};
      reg_model[i] = 32'hA5A5_0000 + i;
      @(negedge clk);
    end
    writeback = '{valid: 1'b1, rd: 5'd0, data: 32'hDEAD_BEEF};
    @(negedge clk);
    writeback = '0;

    // Program words first and an addi x0 fill keyed by word index after them
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem_wr = '{valid: 1'b1, addr: i, data: (i < NUM_WORDS) ? raw_tab[i] :
                                                   {i[11:0], 20'h00013}};
      @(negedge clk);
    end
    imem_wr = '0;

    redirect = '{valid: 1'b1, pc: 32'd0};
    @(negedge clk);
    redirect = '0;
    while (out_idx < NUM_WORDS) begin
      step();
    end

    // Stall with a valid output, then redirect back to word 2
    decoded_ready = 1'b0;
    writeback     = '0;
    while (!decoded_valid) begin
      @(negedge clk);
    end
    redirect = '{valid: 1'b1, pc: 32'd8};
    out_idx  = 2;
    @(negedge clk);
    redirect = '0;
    while (out_idx < NUM_WORDS) begin
      step();
    end
    repeat (4) @(negedge clk);

    $display("Closing report: %0d value errors, %0d assertion errors",
             errors, DUT.u_asserts.fail_count);
    if ((errors == 0) && (DUT.u_asserts.fail_count == 0)) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * 10);
    $display("Timeout: only %0d decoded outputs arrived before the time limit", out_idx);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire
